//--- hw/tile_params.svh
`ifndef TILE_PARAMS_SVH
`define TILE_PARAMS_SVH

// Shared memory geometry

`define TILE_MEM_WORDS 256     // Depth of the on-chip memory in words

`define TILE_MEM_AW 8          // Word index bits used by the memory

// Test stimulus sizing

`define TILE_STIM_LINES 20     // Access lines in the stimulus file

// Memory index must cover the whole array
// so TILE_MEM_WORDS is 2 to the power TILE_MEM_AW

`endif

//--- hw/tile_pkg.sv
`default_nettype none

package tile_pkg;

    typedef logic [31:0] byte_addr_t;       // Core side byte address
    typedef logic [31:0] word_addr_t;       // Bus side word address with top bits zero
    typedef logic [31:0] data_t;            // One bus word
    typedef logic [3:0]  sel_t;             // One bit per byte lane

    // Encoded as log2 of the access width in bytes
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_e;

    typedef enum logic [1:0] {
        arb_idle    = 2'd0,                 // Shared bus free
        arb_grant_i = 2'd1,                 // Instruction master owns the bus
        arb_grant_d = 2'd2                  // Data master owns the bus
    } arb_state_e;

    typedef struct packed {
        logic         cyc;
        logic         stb;
        logic         we;                   // Ignored on the instruction port
        byte_addr_t   adr;
        access_size_e size;
        data_t        dat;                  // Store data in the low lanes
    } core_req_t;

    typedef struct packed {
        logic  ack;                         // One cycle pulse
        data_t dat;                         // Load data zero-extended
    } core_rsp_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        word_addr_t adr;
        sel_t       sel;
        data_t      dat;                    // Write data already in its lanes
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        data_t dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- hw/core_bus_adapter.sv
`timescale 1ns/1ns
`default_nettype none

module core_bus_adapter (
    input  wire logic                clk_i,
    input  wire logic                arst_n_i,
    input  wire logic                en_i,          // Core enable level
    input  wire tile_pkg::core_req_t icore_req_i,   // Instruction fetch port
    input  wire tile_pkg::core_req_t dcore_req_i,   // Load and store port
    output tile_pkg::core_rsp_t      icore_rsp_o,
    output tile_pkg::core_rsp_t      dcore_rsp_o,
    output tile_pkg::wb_req_t        iwb_req_o,
    output tile_pkg::wb_req_t        dwb_req_o,
    input  wire tile_pkg::wb_rsp_t   iwb_rsp_i,
    input  wire tile_pkg::wb_rsp_t   dwb_rsp_i
);

    logic ibusy_q;                                  // Instruction cycle already on the bus
    logic dbusy_q;                                  // Data cycle already on the bus
    logic ipass;                                    // Instruction request reaches the bus
    logic dpass;                                    // Data request reaches the bus

    // Byte offset inside the word with the bits below the size cleared
    function automatic logic [1:0] lane_ofs(input tile_pkg::access_size_e size,
                                            input tile_pkg::byte_addr_t   adr);
        case (size)
            tile_pkg::size_byte: lane_ofs = adr[1:0];
            tile_pkg::size_half: lane_ofs = {adr[1], 1'b0};
            default:             lane_ofs = 2'b00;
        endcase
    endfunction

    // Core request to Wishbone master request
    function automatic tile_pkg::wb_req_t to_wb(input tile_pkg::core_req_t req,
                                                input logic                pass);
        logic [1:0]        ofs;
        tile_pkg::wb_req_t wb;
        ofs    = lane_ofs(req.size, req.adr);
        wb.cyc = pass;
        wb.stb = pass;
        wb.we  = pass & req.we;
        wb.adr = {2'b00, req.adr[31:2]};            // Byte to word address
        case (req.size)
            tile_pkg::size_byte: begin
                wb.sel = 4'b0001 << ofs;
                wb.dat = {24'd0, req.dat[7:0]} << {ofs, 3'b000};
            end
            tile_pkg::size_half: begin
                wb.sel = 4'b0011 << ofs;
                wb.dat = {16'd0, req.dat[15:0]} << {ofs, 3'b000};
            end
            default: begin
                wb.sel = 4'b1111;
                wb.dat = req.dat;
            end
        endcase
        return wb;
    endfunction

    // Wishbone response back to the core lanes
    function automatic tile_pkg::core_rsp_t to_core(input tile_pkg::wb_rsp_t   rsp,
                                                    input tile_pkg::core_req_t req);
        tile_pkg::data_t     shifted;
        tile_pkg::core_rsp_t crsp;
        shifted  = rsp.dat >> {lane_ofs(req.size, req.adr), 3'b000};
        crsp.ack = rsp.ack;
        case (req.size)
            tile_pkg::size_byte: crsp.dat = {24'd0, shifted[7:0]};
            tile_pkg::size_half: crsp.dat = {16'd0, shifted[15:0]};
            default:             crsp.dat = shifted;
        endcase
        return crsp;
    endfunction

    // New cycles need en_i while a started cycle runs to its ack
    assign ipass = icore_req_i.cyc & icore_req_i.stb & (en_i | ibusy_q);
    assign dpass = dcore_req_i.cyc & dcore_req_i.stb & (en_i | dbusy_q);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ibusy_q <= 1'b0;
            dbusy_q <= 1'b0;
        end else begin
            ibusy_q <= ipass & ~iwb_rsp_i.ack;      // Clears on the ack edge
            dbusy_q <= dpass & ~dwb_rsp_i.ack;
        end
    end

    always_comb begin
        iwb_req_o    = to_wb(icore_req_i, ipass);
        iwb_req_o.we = 1'b0;                        // Fetch port never writes
        dwb_req_o    = to_wb(dcore_req_i, dpass);
        icore_rsp_o  = to_core(iwb_rsp_i, icore_req_i);
        dcore_rsp_o  = to_core(dwb_rsp_i, dcore_req_i);
    end

endmodule

`default_nettype wire

//--- hw/bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
    input  wire logic              clk_i,
    input  wire logic              arst_n_i,
    input  wire tile_pkg::wb_req_t iwb_req_i,      // Instruction master
    input  wire tile_pkg::wb_req_t dwb_req_i,      // Data master
    output tile_pkg::wb_rsp_t      iwb_rsp_o,
    output tile_pkg::wb_rsp_t      dwb_rsp_o,
    output tile_pkg::wb_req_t      mem_req_o,      // Shared bus to the memory
    input  wire tile_pkg::wb_rsp_t mem_rsp_i
);

    tile_pkg::arb_state_e state_q;
    tile_pkg::arb_state_e state_d;
    logic                 last_d_q;                 // Data master served last
    logic                 ireq;
    logic                 dreq;

    assign ireq = iwb_req_i.cyc & iwb_req_i.stb;
    assign dreq = dwb_req_i.cyc & dwb_req_i.stb;

    // Grant decision
    always_comb begin
        state_d = state_q;
        case (state_q)
            tile_pkg::arb_idle: begin
                if (ireq && (!dreq || last_d_q)) begin
                    state_d = tile_pkg::arb_grant_i;    // Alone or its turn
                end else if (dreq) begin
                    state_d = tile_pkg::arb_grant_d;
                end
            end
            tile_pkg::arb_grant_i: begin
                if (mem_rsp_i.ack || !ireq) begin
                    state_d = tile_pkg::arb_idle;
                end
            end
            tile_pkg::arb_grant_d: begin
                if (mem_rsp_i.ack || !dreq) begin
                    state_d = tile_pkg::arb_idle;
                end
            end
            default: state_d = tile_pkg::arb_idle;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= tile_pkg::arb_idle;
            last_d_q <= 1'b0;                       // Data wins the first tie
        end else begin
            state_q <= state_d;
            if (mem_rsp_i.ack) begin
                last_d_q <= (state_q == tile_pkg::arb_grant_d);
            end
        end
    end

    // Bus mux and response routing
    always_comb begin
        mem_req_o = '0;                             // Idle bus has cyc and stb low
        iwb_rsp_o = '0;
        dwb_rsp_o = '0;
        case (state_q)
            tile_pkg::arb_grant_i: begin
                mem_req_o = iwb_req_i;
                iwb_rsp_o = mem_rsp_i;
            end
            tile_pkg::arb_grant_d: begin
                mem_req_o = dwb_req_i;
                dwb_rsp_o = mem_rsp_i;
            end
            default: begin
                mem_req_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/wb_sram.sv
`timescale 1ns/1ns
`default_nettype none

`include "tile_params.svh"

module wb_sram (
    input  wire logic              clk_i,
    input  wire logic              arst_n_i,
    input  wire tile_pkg::wb_req_t mem_req_i,
    output tile_pkg::wb_rsp_t      mem_rsp_o
);

    tile_pkg::data_t         mem_q [`TILE_MEM_WORDS];   // Storage array
    tile_pkg::data_t         rdat_q;                    // Registered read word
    logic [`TILE_MEM_AW-1:0] idx;
    logic                    ack_q;
    logic                    hit;                       // First cycle of an access

    assign idx = mem_req_i.adr[`TILE_MEM_AW-1:0];       // Low word address bits only
    assign hit = mem_req_i.cyc & mem_req_i.stb & ~ack_q;

    // Single pulse per access
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= hit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (hit) begin
            rdat_q <= mem_q[idx];                       // Old word on a write
            if (mem_req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_req_i.sel[b]) begin
                        mem_q[idx][8*b +: 8] <= mem_req_i.dat[8*b +: 8];
                    end
                end
            end
        end
    end

    assign mem_rsp_o = '{ack: ack_q, dat: rdat_q};

endmodule

`default_nettype wire

//--- hw/cpu_bus_tile.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_bus_tile (
    input  wire logic                clk_i,
    input  wire logic                arst_n_i,
    input  wire logic                en_i,          // Core enable level
    input  wire tile_pkg::core_req_t icore_req_i,   // Instruction port from the core
    input  wire tile_pkg::core_req_t dcore_req_i,   // Data port from the core
    output tile_pkg::core_rsp_t      icore_rsp_o,
    output tile_pkg::core_rsp_t      dcore_rsp_o
);

    // Word addressed masters
    tile_pkg::wb_req_t iwb_req;
    tile_pkg::wb_req_t dwb_req;
    tile_pkg::wb_rsp_t iwb_rsp;
    tile_pkg::wb_rsp_t dwb_rsp;

    // Shared memory bus
    tile_pkg::wb_req_t mem_req;
    tile_pkg::wb_rsp_t mem_rsp;

    core_bus_adapter i_adapter (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .en_i        (en_i),
        .icore_req_i (icore_req_i),
        .dcore_req_i (dcore_req_i),
        .icore_rsp_o (icore_rsp_o),
        .dcore_rsp_o (dcore_rsp_o),
        .iwb_req_o   (iwb_req),
        .dwb_req_o   (dwb_req),
        .iwb_rsp_i   (iwb_rsp),
        .dwb_rsp_i   (dwb_rsp)
    );

    // Round-robin between fetch and data
    bus_arbiter i_arbiter (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .iwb_req_i (iwb_req),
        .dwb_req_i (dwb_req),
        .iwb_rsp_o (iwb_rsp),
        .dwb_rsp_o (dwb_rsp),
        .mem_req_o (mem_req),
        .mem_rsp_i (mem_rsp)
    );

    wb_sram i_sram (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

endmodule

`default_nettype wire

//--- tb/cpu_bus_tile_sva.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_bus_tile_sva (
    input wire logic              clk_i,
    input wire logic              arst_n_i,
    input wire tile_pkg::wb_rsp_t iwb_rsp_i,        // Response routed to the fetch master
    input wire tile_pkg::wb_rsp_t dwb_rsp_i,        // Response routed to the data master
    input wire tile_pkg::wb_req_t mem_req_i,        // Shared bus request
    input wire tile_pkg::wb_rsp_t mem_rsp_i
);

    // Only the granted master may see ack
    one_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(iwb_rsp_i.ack && dwb_rsp_i.ack))
        else $error("both masters saw ack in the same cycle");

    stb_in_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        mem_req_i.stb |-> mem_req_i.cyc)
        else $error("shared bus strobe raised outside a cycle");

    // Granted request holds its address until the memory acks
    adr_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (mem_req_i.stb && !mem_rsp_i.ack) |=> $stable(mem_req_i.adr))
        else $error("shared bus address changed before ack");

endmodule

bind bus_arbiter cpu_bus_tile_sva i_sva (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .iwb_rsp_i (iwb_rsp_o),
    .dwb_rsp_i (dwb_rsp_o),
    .mem_req_i (mem_req_o),
    .mem_rsp_i (mem_rsp_i)
);

`default_nettype wire

//--- tb/tb_cpu_bus_tile.sv
`timescale 1ns/1ns
`default_nettype none

`include "tile_params.svh"

module tb_cpu_bus_tile;

    localparam int MAX_LINES    = `TILE_STIM_LINES;
    localparam int RESET_CYCLES = 10;
    localparam int LINE_CYCLES  = 40;               // Cycle budget per access line
    localparam int OFF_CYCLES   = 8;                // Cycles held with en_i low

    logic                clk_i = 1'b0;
    logic                arst_n_i;
    logic                en_i;
    tile_pkg::core_req_t icore_req;
    tile_pkg::core_req_t dcore_req;
    tile_pkg::core_rsp_t icore_rsp;
    tile_pkg::core_rsp_t dcore_rsp;

    // Access table loaded from the stimulus file
    logic [7:0]             port_q [MAX_LINES];     // i or d
    logic [7:0]             op_q   [MAX_LINES];     // r, w or n
    tile_pkg::access_size_e size_q [MAX_LINES];
    logic [31:0]            adr_q  [MAX_LINES];
    logic [31:0]            wdat_q [MAX_LINES];
    logic [31:0]            exp_q  [MAX_LINES];
    int                     dep_q  [MAX_LINES];     // Earlier line that must finish first
    logic                   done_q [MAX_LINES];
    int                     num_lines;
    int                     lines_done;             // Shared completion counter

    cpu_bus_tile i_dut (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .en_i        (en_i),
        .icore_req_i (icore_req),
        .dcore_req_i (dcore_req),
        .icore_rsp_o (icore_rsp),
        .dcore_rsp_o (dcore_rsp)
    );

    always #2 clk_i = ~clk_i;                       // 4 ns period

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error at %0t ns: %s, got %08h, expected %08h",
                                        $time, what, actual, expected));
        end
    endtask

    // Xorshift step for idle gaps
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Lines on different ports that must keep file order
    function automatic logic conflicts(input int j, input int k);
        if (port_q[j] == port_q[k]) begin
            return 1'b0;                            // Same driver keeps order anyway
        end
        if (op_q[j] == "n" || op_q[k] == "n") begin
            return 1'b1;                            // Disabled window stands alone
        end
        return (adr_q[j][31:2] == adr_q[k][31:2]) && (op_q[j] == "w" || op_q[k] == "w");
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          n;
        int          size_v;
        string       line;
        logic [7:0]  port_v;
        logic [7:0]  op_v;
        logic [31:0] adr_v;
        logic [31:0] wdat_v;
        logic [31:0] exp_v;
        num_lines = 0;
        fd = $fopen("tb/tile_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open the stimulus file tb/tile_stimulus.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %c %d %h %h %h",
                                port_v, op_v, size_v, adr_v, wdat_v, exp_v);
                    if (n != 6 || num_lines >= MAX_LINES || size_v < 0 || size_v > 2 ||
                        (port_v != "i" && port_v != "d") ||
                        (op_v != "r" && op_v != "w" && op_v != "n")) begin
                        stop_with_failure($sformatf("malformed stimulus line: %s", line));
                    end else begin
                        port_q[num_lines] = port_v;
                        op_q[num_lines]   = op_v;
                        size_q[num_lines] = tile_pkg::access_size_e'(size_v[1:0]);
                        adr_q[num_lines]  = adr_v;
                        wdat_q[num_lines] = wdat_v;
                        exp_q[num_lines]  = exp_v;
                        done_q[num_lines] = 1'b0;
                        num_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic find_dependencies();
        for (int k = 0; k < num_lines; k++) begin
            dep_q[k] = -1;
            for (int j = 0; j < k; j++) begin
                if (conflicts(j, k)) begin
                    dep_q[k] = j;                   // Latest one covers the others
                end
            end
        end
    endtask

    task automatic apply_request(input logic is_d, input tile_pkg::core_req_t req);
        if (is_d) begin
            dcore_req = req;
        end else begin
            icore_req = req;
        end
    endtask

    // One core port working through its own lines of the table
    task automatic drive_port(input logic is_d);
        tile_pkg::core_req_t req;
        tile_pkg::core_rsp_t rsp;
        logic [31:0]         rng;
        int                  other_acks;
        logic                got_ack;
        rng = is_d ? next_random(32'd13525) : 32'd13525;
        for (int k = 0; k < num_lines; k++) begin
            if ((port_q[k] == "d") == is_d) begin
                rng = next_random(rng);
                repeat (rng[1:0]) begin             // Idle gap of 0 to 3 cycles
                    @(posedge clk_i);
                    #1;
                end
                while (dep_q[k] >= 0 && !done_q[dep_q[k]]) begin
                    @(posedge clk_i);
                    #1;
                end
                req      = '0;
                req.cyc  = 1'b1;
                req.stb  = 1'b1;
                req.we   = (op_q[k] == "w" || op_q[k] == "n");
                req.adr  = adr_q[k];
                req.size = size_q[k];
                req.dat  = wdat_q[k];
                if (op_q[k] == "n") begin
                    en_i = 1'b0;
                    apply_request(is_d, req);
                    repeat (OFF_CYCLES) begin
                        @(negedge clk_i);
                        check_value(32'(icore_rsp.ack), 32'd0, "instruction ack with en_i low");
                        check_value(32'(dcore_rsp.ack), 32'd0, "data ack with en_i low");
                    end
                end else begin
                    apply_request(is_d, req);
                    other_acks = 0;
                    got_ack    = 1'b0;
                    while (!got_ack) begin
                        @(negedge clk_i);           // Mid-cycle sample
                        rsp     = is_d ? dcore_rsp : icore_rsp;
                        got_ack = rsp.ack;
                        if (!got_ack && (is_d ? icore_rsp.ack : dcore_rsp.ack)) begin
                            other_acks++;
                        end
                    end
                    check_value(32'(other_acks <= 1), 32'd1,
                                $sformatf("line %0d waited on %0d other accesses", k, other_acks));
                    if (op_q[k] == "r") begin
                        check_value(rsp.dat, exp_q[k], $sformatf("line %0d read data", k));
                    end
                end
                done_q[k] = 1'b1;
                lines_done++;
                @(posedge clk_i);
                #1;
                apply_request(is_d, '0);            // Drop stb in the cycle after ack
                if (op_q[k] == "n") begin
                    en_i = 1'b1;                    // Only the disabling line restores it
                end
            end
        end
    endtask

    initial begin : watchdog
        repeat (RESET_CYCLES + MAX_LINES * LINE_CYCLES) @(posedge clk_i);
        stop_with_failure("timeout: the stimulus lines did not complete in the cycle budget");
    end

    initial begin
        arst_n_i   = 1'b0;
        en_i       = 1'b1;
        icore_req  = '0;
        dcore_req  = '0;
        lines_done = 0;
        load_stimulus();
        find_dependencies();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        check_value(32'(icore_rsp.ack | dcore_rsp.ack), 32'd0, "ack right after reset");
        fork
            drive_port(1'b0);
            drive_port(1'b1);
        join
        if (num_lines > 0 && lines_done == num_lines) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            stop_with_failure("not every stimulus line was run to completion");
        end
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+hw
hw/tile_pkg.sv
hw/core_bus_adapter.sv
hw/bus_arbiter.sv
hw/wb_sram.sv
hw/cpu_bus_tile.sv
tb/cpu_bus_tile_sva.sv
tb/tb_cpu_bus_tile.sv

//--- Makefile
# Verilator flow for the CPU bus tile

TOP := tb_cpu_bus_tile

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

# The run may stop early, so the log decides pass or fail
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "^Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/tile_stimulus.txt
# port (i or d), op (r read, w write, n store with enable low), size (0 byte, 1 half, 2 word)
# then byte address, write data and expected read data, all in hex
d w 2 00000000 11223344 00000000
d r 2 00000000 00000000 11223344
d w 2 00000004 aabbccdd 00000000
d w 0 00000005 000000ee 00000000
d w 1 00000007 00009988 00000000
d r 2 00000004 00000000 9988eedd
d r 0 00000005 00000000 000000ee
d r 1 00000006 00000000 00009988
d r 1 00000005 00000000 0000eedd
d w 2 00000103 cafef00d 00000000
i r 2 00000100 00000000 cafef00d
i w 2 00000004 deadbeef 00000000
d w 2 00000200 01020304 00000000
i r 2 00000000 00000000 11223344
d w 1 00000202 0000a5a5 00000000
i r 2 00000004 00000000 9988eedd
d r 2 00000004 00000000 9988eedd
i r 2 00000200 00000000 a5a50304
d n 2 00000000 55555555 00000000
d r 2 00000000 00000000 11223344
